//--- Makefile
# Verilator build and run for the decode branch slice

VERILATOR ?= verilator
TOP       ?= tbDecodeBranch
FILELIST  ?= decodeBranchTop.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

# exit status of the simulation is the test result
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- branchComparator.sv
`timescale 1ns/1ps
`default_nettype none

module branchComparator (
    input  mipsPkg::instrWord                   instr,
    input  logic signed [mipsPkg::dataWidth-1:0] rsData,
    input  logic signed [mipsPkg::dataWidth-1:0] rtData,
    output mipsPkg::brDecision                  decision
);

    //////////////////////////////
    // field views
    //////////////////////////////

    // opcode sits in the same bits for every layout
    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr.rFields.opcode;
    // only meaningful for r-type words
    assign funct  = instr.rFields.funct;

    // operand equality, shared by beq and bne
    logic operandsEqual;

    assign operandsEqual = (rsData == rtData);

    //////////////////////////////
    // decision
    //////////////////////////////

    always_comb begin
        // default: not a control transfer
        decision.isCtrl = 1'b0;
        decision.taken  = 1'b0;
        case (opcode)
            mipsPkg::opBeq: begin
                decision.isCtrl = 1'b1;
                decision.taken  = operandsEqual;
            end
            mipsPkg::opBne: begin
                decision.isCtrl = 1'b1;
                decision.taken  = !operandsEqual;
            end
            // r-type, only jr transfers control
            mipsPkg::opRType: begin
                if (funct == mipsPkg::functJr) begin
                    decision.isCtrl = 1'b1;
                    decision.taken  = 1'b1;
                end
            end
            // unconditional jumps
            mipsPkg::opJ,
            mipsPkg::opJal: begin
                decision.isCtrl = 1'b1;
                decision.taken  = 1'b1;
            end
            // sign-test branches not decoded here
            default: begin
                decision.isCtrl = 1'b0;
                decision.taken  = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- branchTarget.sv
`timescale 1ns/1ps
`default_nettype none

module branchTarget (
    input  logic [mipsPkg::dataWidth-1:0] pc,
    input  mipsPkg::instrWord             instr,
    input  logic [mipsPkg::dataWidth-1:0] rsData,
    input  mipsPkg::brDecision            decision,
    output logic [mipsPkg::dataWidth-1:0] nextPc,
    output logic [mipsPkg::dataWidth-1:0] linkAddr
);

    //////////////////////////////
    // candidate targets
    //////////////////////////////

    logic [mipsPkg::dataWidth-1:0] pcPlus4;
    logic [mipsPkg::dataWidth-1:0] branchOffset;
    logic [mipsPkg::dataWidth-1:0] branchAddr;
    logic [mipsPkg::dataWidth-1:0] jumpAddr;

    // sequential address, no delay slot
    assign pcPlus4 = pc + 32'd4;

    // imm sign-extended, word offset to byte offset
    assign branchOffset = {{14{instr.iFields.imm[15]}}, instr.iFields.imm, 2'b00};
    assign branchAddr   = pcPlus4 + branchOffset;

    // pseudo-direct, keeps the 256 MB region of pc+4
    assign jumpAddr = {pcPlus4[31:28], instr.jFields.target, 2'b00};

    // jal return address
    assign linkAddr = pcPlus4;

    //////////////////////////////
    // next pc select
    //////////////////////////////

    always_comb begin
        nextPc = pcPlus4;
        if (decision.isCtrl && decision.taken) begin
            case (instr.jFields.opcode)
                mipsPkg::opBeq,
                mipsPkg::opBne:   nextPc = branchAddr;
                mipsPkg::opJ,
                mipsPkg::opJal:   nextPc = jumpAddr;
                // jr, register target
                mipsPkg::opRType: nextPc = rsData;
                default:          nextPc = pcPlus4;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- decodeBranchTop.f
mipsPkg.sv
regFile.sv
branchComparator.sv
branchTarget.sv
fetchPc.sv
decodeBranchTop.sv
tbDecodeBranch.sv

//--- decodeBranchTop.sv
`timescale 1ns/1ps
`default_nettype none

module decodeBranchTop (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          stall,
    input  mipsPkg::instrWord             instr,
    input  mipsPkg::wbReq                 wb,
    output logic [mipsPkg::dataWidth-1:0] pc,
    output mipsPkg::brDecision            decision,
    output logic [mipsPkg::dataWidth-1:0] nextPc,
    output logic [mipsPkg::dataWidth-1:0] linkAddr,
    output logic [mipsPkg::dataWidth-1:0] rsData,
    output logic [mipsPkg::dataWidth-1:0] rtData
);

    //////////////////////////////
    // operand read
    //////////////////////////////

    // rs and rt share bit positions in r and i layouts
    regFile uRegFile (
        .clk    (clk),
        .arstN  (arstN),
        .wb     (wb),
        .rsAddr (instr.iFields.rs),
        .rtAddr (instr.iFields.rt),
        .rsData (rsData),
        .rtData (rtData)
    );

    //////////////////////////////
    // resolve and redirect
    //////////////////////////////

    // taken / control-transfer flags
    branchComparator uComparator (
        .instr    (instr),
        .rsData   (rsData),
        .rtData   (rtData),
        .decision (decision)
    );

    // target math and next pc mux
    branchTarget uTarget (
        .pc       (pc),
        .instr    (instr),
        .rsData   (rsData),
        .decision (decision),
        .nextPc   (nextPc),
        .linkAddr (linkAddr)
    );

    // pc register closes the loop
    fetchPc uFetchPc (
        .clk    (clk),
        .arstN  (arstN),
        .stall  (stall),
        .nextPc (nextPc),
        .pc     (pc)
    );

endmodule

`default_nettype wire

//--- fetchPc.sv
`timescale 1ns/1ps
`default_nettype none

module fetchPc (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          stall,
    input  logic [mipsPkg::dataWidth-1:0] nextPc,
    output logic [mipsPkg::dataWidth-1:0] pc
);

    //////////////////////////////
    // pc register
    //////////////////////////////

    // architectural pc, drives fetch and target math
    logic [mipsPkg::dataWidth-1:0] pcReg;

    // reset goes straight to the boot address
    // otherwise load every edge that is not stalled
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcReg <= mipsPkg::resetVector;
        end else if (!stall) begin
            pcReg <= nextPc;
        end
        // stall high: hold current fetch address
    end

    // registered output only
    assign pc = pcReg;

endmodule

`default_nettype wire

//--- mipsPkg.sv
`default_nettype none

package mipsPkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    // datapath word and register file geometry
    localparam int dataWidth    = 32;
    localparam int regCount     = 32;
    localparam int regAddrWidth = 5;

    //////////////////////////////
    // encodings
    //////////////////////////////

    // primary opcodes, bits 31:26
    localparam logic [5:0] opRType = 6'b000000;
    localparam logic [5:0] opJ     = 6'b000010;
    localparam logic [5:0] opJal   = 6'b000011;
    localparam logic [5:0] opBeq   = 6'b000100;
    localparam logic [5:0] opBne   = 6'b000101;

    // funct field of r-type words, bits 5:0
    localparam logic [5:0] functJr = 6'b001000;

    // jal return address register
    localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

    // first fetch address
    localparam logic [dataWidth-1:0] resetVector = 32'h0000_0000;

    //////////////////////////////
    // instruction layouts
    //////////////////////////////

    // register format
    typedef struct packed {
        logic [5:0]              opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        logic [4:0]              shamt;
        logic [5:0]              funct;
    } rFormat;

    // immediate format, beq and bne
    typedef struct packed {
        logic [5:0]              opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [15:0]             imm;
    } iFormat;

    // jump format, j and jal
    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } jFormat;

    // one 32-bit word, three views
    typedef union packed {
        rFormat rFields;
        iFormat iFields;
        jFormat jFields;
    } instrWord;

    //////////////////////////////
    // shared bundles
    //////////////////////////////

    // writeback port from the later stage
    typedef struct packed {
        logic                    enable;
        logic [regAddrWidth-1:0] addr;
        logic [dataWidth-1:0]    data;
    } wbReq;

    // comparator result
    typedef struct packed {
        logic isCtrl;
        logic taken;
    } brDecision;

endpackage

`default_nettype wire

//--- regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                                 clk,
    input  logic                                 arstN,
    input  mipsPkg::wbReq                        wb,
    input  logic [mipsPkg::regAddrWidth-1:0]     rsAddr,
    input  logic [mipsPkg::regAddrWidth-1:0]     rtAddr,
    output logic [mipsPkg::dataWidth-1:0]        rsData,
    output logic [mipsPkg::dataWidth-1:0]        rtData
);

    // register 0 has no storage
    logic [mipsPkg::dataWidth-1:0] regs [1:mipsPkg::regCount-1];

    //////////////////////////////
    // write port
    //////////////////////////////

    // writes to r0 are dropped
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < mipsPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.enable && (wb.addr != '0)) begin
            regs[wb.addr] <= wb.data;
        end
    end

    //////////////////////////////
    // read ports
    //////////////////////////////

    // one lookup shared by both ports
    function automatic logic [mipsPkg::dataWidth-1:0] readPort(
        input logic [mipsPkg::regAddrWidth-1:0] addr
    );
        logic [mipsPkg::dataWidth-1:0] value;
        if (addr == '0) begin
            // r0 hardwired
            value = '0;
        end else if (wb.enable && (wb.addr == addr)) begin
            // same-cycle write forwarded
            value = wb.data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rsData = readPort(rsAddr);
        rtData = readPort(rtAddr);
    end

endmodule

`default_nettype wire

//--- tbDecodeBranch.sv
`timescale 1ns/1ps
`default_nettype none

module tbDecodeBranch;

    // test lengths in cycles
    localparam int resetCycles   = 2;
    localparam int resetChecks   = 8;
    localparam int regTests      = 100;
    localparam int branchPairs   = 60;
    localparam int jumpTests     = 80;
    localparam int otherTests    = 100;
    localparam int stallTests    = 150;
    localparam int plannedCycles = 2 * (resetCycles + resetChecks) + regTests + 2 * branchPairs
                                 + jumpTests + otherTests + stallTests;
    localparam int timeoutCycles = 4 * plannedCycles;

    logic                          clk;
    logic                          arstN;
    logic                          stall;
    mipsPkg::instrWord             instr;
    mipsPkg::wbReq                 wb;
    logic [mipsPkg::dataWidth-1:0] pc;
    mipsPkg::brDecision            decision;
    logic [mipsPkg::dataWidth-1:0] nextPc;
    logic [mipsPkg::dataWidth-1:0] linkAddr;
    logic [mipsPkg::dataWidth-1:0] rsData;
    logic [mipsPkg::dataWidth-1:0] rtData;

    // reference state
    logic [31:0] modelRegs [0:31];
    logic [31:0] modelPc;
    logic [31:0] lcgState;
    string       testName;
    int          cycleCount = 0;

    decodeBranchTop dut (
        .clk      (clk),
        .arstN    (arstN),
        .stall    (stall),
        .instr    (instr),
        .wb       (wb),
        .pc       (pc),
        .decision (decision),
        .nextPc   (nextPc),
        .linkAddr (linkAddr),
        .rsData   (rsData),
        .rtData   (rtData)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////
    // reporting
    //////////////////////////////

    task automatic failRun(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic checkWord(input string name, input logic [31:0] expVal,
                             input logic [31:0] actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("CHECK FAILED %s expected %h actual %h", name, expVal, actVal));
        end
    endtask

    task automatic checkDecision(input string name, input mipsPkg::brDecision expVal,
                                 input mipsPkg::brDecision actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("CHECK FAILED %s expected %b actual %b", name, expVal, actVal));
        end
    endtask

    // hang guard
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > timeoutCycles) begin
            failRun($sformatf("timeout after %0d cycles, tests did not finish", cycleCount));
        end
    end

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        // upper half carries the better bits
        return {lcgState[15:0], lcgState[31:16]};
    endfunction

    // r0 reads zero and a same-cycle write wins
    function automatic logic [31:0] modelRead(input logic [4:0] addr, input mipsPkg::wbReq wr);
        if (addr == 5'd0) begin
            return 32'd0;
        end
        if (wr.enable && wr.addr == addr) begin
            return wr.data;
        end
        return modelRegs[addr];
    endfunction

    function automatic mipsPkg::brDecision modelDecision(input mipsPkg::instrWord ins,
                                                         input logic [31:0] a,
                                                         input logic [31:0] b);
        mipsPkg::brDecision d;
        d = '0;
        if (ins.iFields.opcode == mipsPkg::opBeq) begin
            d.isCtrl = 1'b1;
            d.taken  = (a == b);
        end else if (ins.iFields.opcode == mipsPkg::opBne) begin
            d.isCtrl = 1'b1;
            d.taken  = (a != b);
        end else if (ins.jFields.opcode == mipsPkg::opJ || ins.jFields.opcode == mipsPkg::opJal) begin
            d = 2'b11;
        end else if (ins.rFields.opcode == mipsPkg::opRType
                     && ins.rFields.funct == mipsPkg::functJr) begin
            d = 2'b11;
        end
        return d;
    endfunction

    function automatic logic [31:0] modelNextPc(input logic [31:0] curPc,
                                                input mipsPkg::instrWord ins,
                                                input logic [31:0] rsVal,
                                                input mipsPkg::brDecision d);
        logic [31:0] seq;
        logic [31:0] offset;
        seq    = curPc + 32'd4;
        offset = {{16{ins.iFields.imm[15]}}, ins.iFields.imm};
        if (!d.taken) begin
            return seq;
        end
        if (ins.iFields.opcode == mipsPkg::opBeq || ins.iFields.opcode == mipsPkg::opBne) begin
            return seq + (offset << 2);
        end
        if (ins.jFields.opcode == mipsPkg::opRType) begin
            return rsVal;
        end
        return {seq[31:28], ins.jFields.target, 2'b00};
    endfunction

    //////////////////////////////
    // stimulus builders
    //////////////////////////////

    function automatic mipsPkg::wbReq randWb();
        mipsPkg::wbReq w;
        logic [31:0] r;
        r        = lcgNext();
        w.enable = r[0] | r[1];
        w.addr   = r[12:8];
        // r0 writes now and then
        if (r[4:2] == 3'd0) begin
            w.addr = 5'd0;
        end
        w.data = lcgNext();
        return w;
    endfunction

    function automatic logic controlOpcode(input logic [5:0] op);
        return op == mipsPkg::opRType || op == mipsPkg::opJ || op == mipsPkg::opJal
            || op == mipsPkg::opBeq || op == mipsPkg::opBne;
    endfunction

    // r-type with any funct but jr
    function automatic mipsPkg::instrWord rTypeNonJr();
        mipsPkg::instrWord w;
        w = lcgNext();
        w.rFields.opcode = mipsPkg::opRType;
        if (w.rFields.funct == mipsPkg::functJr) begin
            w.rFields.funct = 6'h20;
        end
        return w;
    endfunction

    function automatic mipsPkg::instrWord otherInstr();
        mipsPkg::instrWord w;
        logic [31:0] r;
        r = lcgNext();
        if (r[0]) begin
            return rTypeNonJr();
        end
        w = lcgNext();
        // step of 7 walks all 64 opcodes
        while (controlOpcode(w.iFields.opcode)) begin
            w.iFields.opcode = w.iFields.opcode + 6'd7;
        end
        return w;
    endfunction

    function automatic mipsPkg::instrWord branchInstr(input logic [5:0] op, input logic [4:0] rs,
                                                      input logic [4:0] rt);
        mipsPkg::instrWord w;
        w = lcgNext();
        w.iFields.opcode = op;
        w.iFields.rs     = rs;
        w.iFields.rt     = rt;
        return w;
    endfunction

    function automatic mipsPkg::instrWord jumpInstr();
        mipsPkg::instrWord w;
        logic [31:0] r;
        r = lcgNext();
        w = lcgNext();
        if (r[1:0] == 2'd0) begin
            w.jFields.opcode = mipsPkg::opJ;
        end else if (r[1:0] == 2'd1) begin
            w.jFields.opcode = mipsPkg::opJal;
        end else begin
            // jr through a random register
            w.rFields.opcode = mipsPkg::opRType;
            w.rFields.funct  = mipsPkg::functJr;
        end
        return w;
    endfunction

    function automatic mipsPkg::instrWord anyInstr();
        logic [31:0] r;
        r = lcgNext();
        case (r[1:0])
            2'd0:    return otherInstr();
            2'd1:    return jumpInstr();
            2'd2:    return branchInstr(mipsPkg::opBeq, r[8:4], r[13:9]);
            default: return branchInstr(mipsPkg::opBne, r[8:4], r[13:9]);
        endcase
    endfunction

    //////////////////////////////
    // drive and check one cycle
    //////////////////////////////

    task automatic runCycle(input mipsPkg::instrWord ins, input mipsPkg::wbReq wr,
                            input logic stl);
        logic [31:0]        expRs;
        logic [31:0]        expRt;
        logic [31:0]        expNext;
        mipsPkg::brDecision expDec;
        @(posedge clk);
        #1;
        instr = ins;
        wb    = wr;
        stall = stl;
        // combinational outputs settle
        #2;
        expRs   = modelRead(ins.iFields.rs, wr);
        expRt   = modelRead(ins.iFields.rt, wr);
        expDec  = modelDecision(ins, expRs, expRt);
        expNext = modelNextPc(modelPc, ins, expRs, expDec);
        checkWord({testName, " pc"}, modelPc, pc);
        checkWord({testName, " rsData"}, expRs, rsData);
        checkWord({testName, " rtData"}, expRt, rtData);
        checkDecision({testName, " decision"}, expDec, decision);
        checkWord({testName, " nextPc"}, expNext, nextPc);
        checkWord({testName, " linkAddr"}, modelPc + 32'd4, linkAddr);
        // model state follows the coming edge
        if (wr.enable && wr.addr != 5'd0) begin
            modelRegs[wr.addr] = wr.data;
        end
        if (!stl) begin
            modelPc = expNext;
        end
    endtask

    // reset asserted between edges, then a cleared pc and register file expected
    task automatic resetAndCheck(input string name);
        arstN = 1'b0;
        // stall high so the first edge after release holds pc
        stall = 1'b1;
        instr = '0;
        // no write pending at release
        wb    = '0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = 32'd0;
        end
        modelPc = mipsPkg::resetVector;
        repeat (resetCycles) @(posedge clk);
        #1;
        arstN    = 1'b1;
        testName = name;
        checkWord({name, " pc"}, mipsPkg::resetVector, pc);
        checkDecision({name, " decision"}, 2'b00, decision);
        repeat (resetChecks) runCycle(rTypeNonJr(), '0, 1'b1);
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        mipsPkg::instrWord ins;
        mipsPkg::wbReq     wr;
        logic [31:0]       r;
        logic [31:0]       valA;
        logic [31:0]       valB;
        logic [4:0]        rsA;
        logic [4:0]        rtA;
        lcgState = 32'd13546;
        resetAndCheck("reset");

        testName = "regfile";
        for (int i = 0; i < regTests; i++) begin
            wr  = randWb();
            ins = rTypeNonJr();
            r   = lcgNext();
            // aim a read port at the write to hit the bypass
            if (r[0]) begin
                ins.rFields.rs = wr.addr;
            end
            if (r[1]) begin
                ins.rFields.rt = wr.addr;
            end
            runCycle(ins, wr, 1'b0);
        end

        // second reset with written registers and a moved pc
        resetAndCheck("reset after writes");

        testName = "branch";
        for (int i = 0; i < branchPairs; i++) begin
            r    = lcgNext();
            rsA  = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
            rtA  = (r[9:5] == 5'd0) ? 5'd2 : r[9:5];
            valA = lcgNext();
            valB = r[10] ? valA : lcgNext();
            runCycle(rTypeNonJr(), '{enable: 1'b1, addr: rsA, data: valA}, 1'b0);
            // rt arrives through the bypass
            ins = branchInstr(r[11] ? mipsPkg::opBeq : mipsPkg::opBne, rsA, rtA);
            runCycle(ins, '{enable: 1'b1, addr: rtA, data: valB}, 1'b0);
        end

        testName = "jump";
        repeat (jumpTests) runCycle(jumpInstr(), randWb(), 1'b0);

        testName = "other";
        repeat (otherTests) runCycle(otherInstr(), randWb(), 1'b0);

        testName = "stall";
        for (int i = 0; i < stallTests; i++) begin
            r = lcgNext();
            runCycle(anyInstr(), randWb(), r[3]);
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
